/* src/rv_pkg.sv */
// data widths, major opcodes and one-hot alu operation indices.
package rv_pkg;

  // datapath and instruction widths.
  localparam int xlen     = 64;
  localparam int inst_w   = 32;
  localparam int reg_id_w = 5;

  // major opcodes, inst[6:0].
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op        = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] lui       = 7'b0110111;
  localparam logic [6:0] auipc     = 7'b0010111;
  localparam logic [6:0] system    = 7'b1110011;

  // width of the one-hot alu operation vector.
  localparam int alu_op_w = 16;

  // bit positions in the alu operation vector.
  // 64-bit operations.
  localparam int alu_add     = 0;
  localparam int alu_sub     = 1;
  localparam int alu_lt      = 2;
  localparam int alu_ltu     = 3;
  localparam int alu_and     = 4;
  localparam int alu_or      = 5;
  localparam int alu_xor     = 6;
  localparam int alu_sll     = 7;
  localparam int alu_srl     = 8;
  localparam int alu_sra     = 9;

  // passes operand b, used by lui.
  localparam int alu_out_imm = 10;

  // word operations, result sign-extended from bit 31.
  localparam int alu_addw    = 11;
  localparam int alu_subw    = 12;
  localparam int alu_sllw    = 13;
  localparam int alu_srlw    = 14;
  localparam int alu_sraw    = 15;

endpackage

/* src/rv_decoder.sv */
// combinational instruction decoder: register indices, immediate, alu operation and flags.
`timescale 1ns/100ps

module rv_decoder (
  input  logic [rv_pkg::inst_w-1:0]   inst_q,
  output logic [rv_pkg::reg_id_w-1:0] rd,
  output logic [rv_pkg::reg_id_w-1:0] rs1,
  output logic [rv_pkg::reg_id_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]     imm,
  output logic                        need_imm,
  output logic                        is_auipc,
  output logic [rv_pkg::alu_op_w-1:0] alu_op,
  output logic                        reg_wen,
  output logic                        is_ebreak,
  output logic                        inst_not_ipl
);
  import rv_pkg::*;

  // opcode classes.
  logic o_imm, o_imm_32, o_op, o_op_32, o_lui, o_auipc, o_system;
  assign o_imm    = (inst_q[6:0] == op_imm);
  assign o_imm_32 = (inst_q[6:0] == op_imm_32);
  assign o_op     = (inst_q[6:0] == op);
  assign o_op_32  = (inst_q[6:0] == op_32);
  assign o_lui    = (inst_q[6:0] == lui);
  assign o_auipc  = (inst_q[6:0] == auipc);
  assign o_system = (inst_q[6:0] == system);

  // funct3 terms.
  logic [2:0] funct3;
  logic f3_000, f3_001, f3_010, f3_011, f3_100, f3_101, f3_110, f3_111;
  assign funct3 = inst_q[14:12];
  assign f3_000 = (funct3 == 3'b000);
  assign f3_001 = (funct3 == 3'b001);
  assign f3_010 = (funct3 == 3'b010);
  assign f3_011 = (funct3 == 3'b011);
  assign f3_100 = (funct3 == 3'b100);
  assign f3_101 = (funct3 == 3'b101);
  assign f3_110 = (funct3 == 3'b110);
  assign f3_111 = (funct3 == 3'b111);

  // funct7 and the 6-bit shift field of rv64 immediate shifts.
  logic f7_zero, f7_alt, sh6_zero, sh6_alt;
  assign f7_zero  = (inst_q[31:25] == 7'b0000000);
  assign f7_alt   = (inst_q[31:25] == 7'b0100000);
  assign sh6_zero = (inst_q[31:26] == 6'b000000);
  assign sh6_alt  = (inst_q[31:26] == 6'b010000);

  // register-immediate.
  logic addi, slti, sltiu, andi, ori, xori, slli, srli, srai;
  assign addi  = o_imm & f3_000;
  assign slti  = o_imm & f3_010;
  assign sltiu = o_imm & f3_011;
  assign andi  = o_imm & f3_111;
  assign ori   = o_imm & f3_110;
  assign xori  = o_imm & f3_100;
  assign slli  = o_imm & f3_001 & sh6_zero;
  assign srli  = o_imm & f3_101 & sh6_zero;
  assign srai  = o_imm & f3_101 & sh6_alt;

  // register-register.
  logic add, sub, slt, sltu, and_op, or_op, xor_op, sll, srl, sra;
  assign add    = o_op & f3_000 & f7_zero;
  assign sub    = o_op & f3_000 & f7_alt;
  assign slt    = o_op & f3_010 & f7_zero;
  assign sltu   = o_op & f3_011 & f7_zero;
  assign and_op = o_op & f3_111 & f7_zero;
  assign or_op  = o_op & f3_110 & f7_zero;
  assign xor_op = o_op & f3_100 & f7_zero;
  assign sll    = o_op & f3_001 & f7_zero;
  assign srl    = o_op & f3_101 & f7_zero;
  assign sra    = o_op & f3_101 & f7_alt;

  // word operations.
  logic addiw, slliw, srliw, sraiw, addw, subw, sllw, srlw, sraw;
  assign addiw = o_imm_32 & f3_000;
  assign slliw = o_imm_32 & f3_001 & f7_zero;
  assign srliw = o_imm_32 & f3_101 & f7_zero;
  assign sraiw = o_imm_32 & f3_101 & f7_alt;
  assign addw  = o_op_32 & f3_000 & f7_zero;
  assign subw  = o_op_32 & f3_000 & f7_alt;
  assign sllw  = o_op_32 & f3_001 & f7_zero;
  assign srlw  = o_op_32 & f3_101 & f7_zero;
  assign sraw  = o_op_32 & f3_101 & f7_alt;

  // ebreak needs the exact encoding, rd and rs1 zero.
  logic ebreak_i;
  assign ebreak_i = o_system & f3_000 & (inst_q[31:20] == 12'h001) &
                    (inst_q[19:15] == 5'd0) & (inst_q[11:7] == 5'd0);

  // immediate, picked by format.
  logic i_type, u_type;
  logic [xlen-1:0] imm_i, imm_u;
  assign i_type = o_imm | o_imm_32;
  assign u_type = o_lui | o_auipc;
  assign imm_i  = {{(xlen-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_u  = {{(xlen-32){inst_q[31]}}, inst_q[31:12], 12'b0};
  assign imm    = ({xlen{i_type}} & imm_i) | ({xlen{u_type}} & imm_u);

  assign rd  = inst_q[11:7];
  assign rs1 = inst_q[19:15];
  assign rs2 = inst_q[24:20];

  // one-hot alu operation.
  assign alu_op[alu_add]     = addi | add | o_auipc;
  assign alu_op[alu_sub]     = sub;
  assign alu_op[alu_lt]      = slti | slt;
  assign alu_op[alu_ltu]     = sltiu | sltu;
  assign alu_op[alu_and]     = andi | and_op;
  assign alu_op[alu_or]      = ori | or_op;
  assign alu_op[alu_xor]     = xori | xor_op;
  assign alu_op[alu_sll]     = slli | sll;
  assign alu_op[alu_srl]     = srli | srl;
  assign alu_op[alu_sra]     = srai | sra;
  assign alu_op[alu_out_imm] = o_lui;
  assign alu_op[alu_addw]    = addiw | addw;
  assign alu_op[alu_subw]    = subw;
  assign alu_op[alu_sllw]    = slliw | sllw;
  assign alu_op[alu_srlw]    = srliw | srlw;
  assign alu_op[alu_sraw]    = sraiw | sraw;

  // every supported computational instruction sets exactly one bit.
  assign reg_wen      = |alu_op;
  assign need_imm     = i_type | u_type;
  assign is_auipc     = o_auipc;
  assign is_ebreak    = ebreak_i;
  assign inst_not_ipl = ~(reg_wen | ebreak_i);

endmodule

/* src/rv_regfile.sv */
// 32 x 64-bit register file, two combinational read ports, one write port, x0 reads zero.
`timescale 1ns/100ps

module rv_regfile (
  input  logic                        clk,
  input  logic                        reset,
  input  logic [rv_pkg::reg_id_w-1:0] rs1,
  input  logic [rv_pkg::reg_id_w-1:0] rs2,
  input  logic                        we,
  input  logic [rv_pkg::reg_id_w-1:0] wa,
  input  logic [rv_pkg::xlen-1:0]     wd,
  output logic [rv_pkg::xlen-1:0]     rs1_data,
  output logic [rv_pkg::xlen-1:0]     rs2_data
);
  import rv_pkg::*;

  // x0 has no storage.
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // reads see the old value during a write cycle.
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/rv_execute.sv */
// operand selection and one-hot alu with 64-bit and word operations.
`timescale 1ns/100ps

module rv_execute (
  input  logic [rv_pkg::alu_op_w-1:0] alu_op,
  input  logic [rv_pkg::xlen-1:0]     rs1_data,
  input  logic [rv_pkg::xlen-1:0]     rs2_data,
  input  logic [rv_pkg::xlen-1:0]     imm,
  input  logic                        need_imm,
  input  logic                        is_auipc,
  input  logic [rv_pkg::xlen-1:0]     pc_q,
  output logic [rv_pkg::xlen-1:0]     result
);
  import rv_pkg::*;

  // sign-extend a word result to xlen.
  function automatic logic [xlen-1:0] sext_w(input logic [31:0] w);
    return {{(xlen-32){w[31]}}, w};
  endfunction

  logic [xlen-1:0] a, b;
  logic [5:0] shamt;
  logic [4:0] shamt_w;

  // operand a is the pc for auipc.
  assign a       = is_auipc ? pc_q : rs1_data;
  assign b       = need_imm ? imm : rs2_data;
  assign shamt   = b[5:0];
  assign shamt_w = b[4:0];

  // 64-bit results.
  logic [xlen-1:0] add_res, sub_res, lt_res, ltu_res;
  logic [xlen-1:0] sll_res, srl_res, sra_res;
  assign add_res = a + b;
  assign sub_res = a - b;
  assign lt_res  = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
  assign ltu_res = {{(xlen-1){1'b0}}, (a < b)};
  assign sll_res = a << shamt;
  assign srl_res = a >> shamt;
  assign sra_res = $unsigned($signed(a) >>> shamt);

  // word results on the low halves.
  logic [31:0] addw_res, subw_res, sllw_res, srlw_res, sraw_res;
  assign addw_res = a[31:0] + b[31:0];
  assign subw_res = a[31:0] - b[31:0];
  assign sllw_res = a[31:0] << shamt_w;
  assign srlw_res = a[31:0] >> shamt_w;
  assign sraw_res = $unsigned($signed(a[31:0]) >>> shamt_w);

  // and-or select; no bit set gives zero.
  assign result =
    ({xlen{alu_op[alu_add]}}     & add_res)          |
    ({xlen{alu_op[alu_sub]}}     & sub_res)          |
    ({xlen{alu_op[alu_lt]}}      & lt_res)           |
    ({xlen{alu_op[alu_ltu]}}     & ltu_res)          |
    ({xlen{alu_op[alu_and]}}     & (a & b))          |
    ({xlen{alu_op[alu_or]}}      & (a | b))          |
    ({xlen{alu_op[alu_xor]}}     & (a ^ b))          |
    ({xlen{alu_op[alu_sll]}}     & sll_res)          |
    ({xlen{alu_op[alu_srl]}}     & srl_res)          |
    ({xlen{alu_op[alu_sra]}}     & sra_res)          |
    ({xlen{alu_op[alu_out_imm]}} & b)                |
    ({xlen{alu_op[alu_addw]}}    & sext_w(addw_res)) |
    ({xlen{alu_op[alu_subw]}}    & sext_w(subw_res)) |
    ({xlen{alu_op[alu_sllw]}}    & sext_w(sllw_res)) |
    ({xlen{alu_op[alu_srlw]}}    & sext_w(srlw_res)) |
    ({xlen{alu_op[alu_sraw]}}    & sext_w(sraw_res));

endmodule

/* src/rv_issue_ctrl.sv */
// four-phase handshake fsm, instruction latch, program counter and registered write-back.
`timescale 1ns/100ps

module rv_issue_ctrl #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        inst_req,
  input  logic [rv_pkg::inst_w-1:0]   inst,
  input  logic [rv_pkg::xlen-1:0]     result,
  input  logic [rv_pkg::reg_id_w-1:0] rd,
  input  logic                        reg_wen,
  input  logic                        is_ebreak,
  input  logic                        inst_not_ipl,
  output logic [rv_pkg::inst_w-1:0]   inst_q,
  output logic                        commit,
  output logic [rv_pkg::xlen-1:0]     pc_q,
  output logic                        inst_ack,
  output logic                        wb_en,
  output logic [rv_pkg::reg_id_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]     wb_data,
  output logic                        illegal,
  output logic                        ebreak
);
  import rv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_exec, st_ack} state_t;
  state_t state;

  // single write strobe, only while executing.
  assign commit = (state == st_exec) && reg_wen;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      inst_ack <= 1'b0;
      wb_en    <= 1'b0;
      illegal  <= 1'b0;
      ebreak   <= 1'b0;
      pc_q     <= reset_pc;
    end else begin
      case (state)
        st_idle: begin
          if (inst_req) state <= st_exec;
        end
        st_exec: begin
          state    <= st_ack;
          inst_ack <= 1'b1;
          wb_en    <= reg_wen;
          illegal  <= inst_not_ipl;
          ebreak   <= is_ebreak;
        end
        st_ack: begin
          // hold everything until the request drops.
          if (!inst_req) begin
            state    <= st_idle;
            inst_ack <= 1'b0;
            pc_q     <= pc_q + xlen'(4);
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload registers.
  always_ff @(posedge clk) begin
    if (state == st_idle && inst_req) inst_q <= inst;
    if (state == st_exec) begin
      wb_rd   <= rd;
      wb_data <= result;
    end
  end

endmodule

/* src/rv_exec_top.sv */
// top level of the rv64i execute subsystem: controller, decoder, register file, execute unit.
`timescale 1ns/100ps

module rv_exec_top #(
  parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        inst_req,
  input  logic [rv_pkg::inst_w-1:0]   inst,
  output logic                        inst_ack,
  output logic                        wb_en,
  output logic [rv_pkg::reg_id_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]     wb_data,
  output logic                        illegal,
  output logic                        ebreak,
  output logic [rv_pkg::xlen-1:0]     pc
);
  import rv_pkg::*;

  logic [inst_w-1:0]   inst_q;
  logic                commit;
  logic [reg_id_w-1:0] rd, rs1, rs2;
  logic [xlen-1:0]     imm;
  logic                need_imm, is_auipc, reg_wen, is_ebreak, inst_not_ipl;
  logic [alu_op_w-1:0] alu_op;
  logic [xlen-1:0]     rs1_data, rs2_data, result;

  rv_issue_ctrl #(.reset_pc(reset_pc)) ctrl_i (
    .clk(clk), .reset(reset), .inst_req(inst_req), .inst(inst),
    .result(result), .rd(rd), .reg_wen(reg_wen), .is_ebreak(is_ebreak),
    .inst_not_ipl(inst_not_ipl), .inst_q(inst_q), .commit(commit), .pc_q(pc),
    .inst_ack(inst_ack), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .illegal(illegal), .ebreak(ebreak)
  );

  rv_decoder decoder_i (
    .inst_q(inst_q), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
    .need_imm(need_imm), .is_auipc(is_auipc), .alu_op(alu_op), .reg_wen(reg_wen),
    .is_ebreak(is_ebreak), .inst_not_ipl(inst_not_ipl)
  );

  // x0 writes are dropped inside the register file.
  rv_regfile regfile_i (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .we(commit), .wa(rd),
    .wd(result), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  rv_execute execute_i (
    .alu_op(alu_op), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .need_imm(need_imm), .is_auipc(is_auipc), .pc_q(pc), .result(result)
  );

endmodule

/* verification/tb_checker.sv */
// reference model of the register file and pc, handshake watch and result comparison.
`timescale 1ns/100ps

module tb_checker #(
  parameter logic [63:0] reset_pc = '0
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        inst_req,
  input  logic [31:0] inst,
  input  logic        inst_ack,
  input  logic        wb_en,
  input  logic [4:0]  wb_rd,
  input  logic [63:0] wb_data,
  input  logic        illegal,
  input  logic        ebreak,
  input  logic [63:0] pc,
  output int          passes,
  output int          errors
);
  logic [63:0] regs [0:31];
  logic [63:0] pc_m;
  logic [31:0] inst_m;
  logic        ack_q;

  task automatic compare(input string name, input logic [63:0] exp_v,
                         input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("error %s expected %h actual %h (inst %h)", name, exp_v, act_v, inst_m);
    end else begin
      passes++;
    end
  endtask

  // 64-bit operation by {funct7, funct3}, returns {valid, value}.
  function automatic logic [64:0] op64(input logic [9:0] code, input logic [63:0] a, b);
    case (code)
      10'h000: return {1'b1, a + b};
      10'h100: return {1'b1, a - b};
      10'h002: return {1'b1, 63'd0, $signed(a) < $signed(b)};
      10'h003: return {1'b1, 63'd0, a < b};
      10'h004: return {1'b1, a ^ b};
      10'h006: return {1'b1, a | b};
      10'h007: return {1'b1, a & b};
      10'h001: return {1'b1, a << b[5:0]};
      10'h005: return {1'b1, a >> b[5:0]};
      10'h105: return {1'b1, 64'($signed(a) >>> b[5:0])};
      default: return '0;
    endcase
  endfunction

  // word operation, sign-extended from bit 31.
  function automatic logic [64:0] op32(input logic [9:0] code, input logic [31:0] a, b);
    logic [31:0] w;
    case (code)
      10'h000: w = a + b;
      10'h100: w = a - b;
      10'h001: w = a << b[4:0];
      10'h005: w = a >> b[4:0];
      10'h105: w = $signed(a) >>> b[4:0];
      default: return '0;
    endcase
    return {1'b1, {32{w[31]}}, w};
  endfunction

  task automatic predict(input logic [31:0] i, output logic [64:0] exp_r, output logic brk);
    logic [63:0] a, b, imm;
    logic [2:0]  f3;
    logic [6:0]  f6_code;
    a   = regs[i[19:15]];
    b   = regs[i[24:20]];
    imm = {{52{i[31]}}, i[31:20]};
    f3  = i[14:12];
    brk = (i == 32'h00100073);
    // immediate shifts carry a 6-bit funct6.
    f6_code = (i[31:26] == 6'h10) ? 7'h20 : ((i[31:26] == 6'h00) ? 7'h00 : 7'h7f);
    case (i[6:0])
      7'b0010011: exp_r = (f3 == 3'd1 || f3 == 3'd5) ?
                          op64({f6_code, f3}, a, {58'd0, i[25:20]}) : op64({7'h00, f3}, a, imm);
      7'b0110011: exp_r = op64({i[31:25], f3}, a, b);
      7'b0011011: exp_r = (f3 == 3'd0) ? op32(10'h000, a[31:0], imm[31:0]) :
                          op32({i[31:25], f3}, a[31:0], {27'd0, i[24:20]});
      7'b0111011: exp_r = op32({i[31:25], f3}, a[31:0], b[31:0]);
      7'b0110111: exp_r = {1'b1, {32{i[31]}}, i[31:12], 12'd0};
      7'b0010111: exp_r = {1'b1, pc_m + {{32{i[31]}}, i[31:12], 12'd0}};
      default:    exp_r = '0;
    endcase
  endtask

  always @(posedge clk) begin
    logic [64:0] exp_r;
    logic        brk;
    if (reset) begin
      for (int k = 0; k < 32; k++) regs[k] = '0;
      pc_m   = reset_pc;
      ack_q  = 1'b0;
      passes = 0;
      errors = 0;
    end else begin
      if (inst_req && !inst_ack) inst_m = inst;
      if (inst_ack && !ack_q) begin
        if (!inst_req) begin
          errors++;
          $display("handshake broken: inst_ack rose while inst_req was low");
        end
        predict(inst_m, exp_r, brk);
        compare("wb_en", 64'(exp_r[64]), 64'(wb_en));
        compare("wb_rd", 64'(inst_m[11:7]), 64'(wb_rd));
        compare("wb_data", exp_r[63:0], wb_data);
        compare("illegal", 64'(!exp_r[64] && !brk), 64'(illegal));
        compare("ebreak", 64'(brk), 64'(ebreak));
        compare("pc", pc_m, pc);
        // x0 keeps reading zero.
        if (exp_r[64] && inst_m[11:7] != 5'd0) regs[inst_m[11:7]] = exp_r[63:0];
        pc_m = pc_m + 64'd4;
      end
      if (!inst_ack && ack_q && inst_req) begin
        errors++;
        $display("handshake broken: inst_ack fell while inst_req was still high");
      end
      ack_q = inst_ack;
    end
  end

endmodule

/* verification/tb_top.sv */
// testbench top: clock, reset, lfsr stimulus, four-phase driver, test sequence, watchdog.
`timescale 1ns/100ps

module tb_top;
  localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;
  // five tests of 200 plus register seeding, at most 20 cycles each.
  localparam int n_inst     = 5 * 200 + 62;
  localparam int timeout_ns = n_inst * 20 * 10;

  // {funct7, funct3} of the register-register and word groups.
  localparam logic [9:0] rr_ops [0:9] = '{10'h000, 10'h100, 10'h002, 10'h003, 10'h007,
                                          10'h006, 10'h004, 10'h001, 10'h005, 10'h105};
  localparam logic [9:0] w_ops [0:4] = '{10'h000, 10'h100, 10'h001, 10'h005, 10'h105};

  logic        clk, reset, inst_req, inst_ack, wb_en, illegal, ebreak;
  logic [31:0] inst, seed;
  logic [4:0]  wb_rd;
  logic [63:0] wb_data, pc;
  int          passes, errors;
  string       test_names [1:5] = '{"register-immediate", "register-register", "word",
                                    "lui/auipc", "illegal/ebreak"};

  rv_exec_top #(.reset_pc(reset_pc)) dut_i (.*);
  tb_checker #(.reset_pc(reset_pc)) checker_i (.*);

  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      seed = lfsr_next(seed);
      v    = {v[30:0], seed[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_inst(input int test);
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [9:0]  code;
    rd  = 5'(rand_bits(5));
    rs1 = 5'(rand_bits(5));
    rs2 = 5'(rand_bits(5));
    f3  = 3'(rand_bits(3));
    imm = 12'(rand_bits(12));
    case (test)
      1: begin
        // shifts want funct6 zero, or 010000 for srai.
        if (f3 == 3'd1 || f3 == 3'd5) imm[11:6] = (f3 == 3'd5 && rs2[0]) ? 6'h10 : 6'h00;
        return {imm, rs1, f3, rd, 7'b0010011};
      end
      2: begin
        code = rr_ops[4'(rand_bits(4) % 10)];
        return {code[9:3], rs2, rs1, code[2:0], rd, 7'b0110011};
      end
      3: begin
        code = w_ops[3'(rand_bits(3) % 5)];
        if (rs2[0]) return {code[9:3], rs2, rs1, code[2:0], rd, 7'b0111011};
        // the subw slot turns into a second addiw.
        if (code[2:0] != 3'd0) imm = {code[9:3], imm[4:0]};
        return {imm, rs1, code[2:0], rd, 7'b0011011};
      end
      4: return {imm, rs1, f3, rd, rs2[0] ? 7'b0110111 : 7'b0010111};
      default: begin
        case (f3)
          3'd0: return 32'h00100073;
          3'd1: return {imm, rs1, rs2[2:0], rd, 7'b0000011};
          3'd2: return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
          3'd3: return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b1100011};
          3'd4: return {imm, rs1, rs2[2:0], rd, 7'b1101111};
          // m extension.
          3'd5: return {7'h01, rs2, rs1, imm[2:0], rd, rs2[0] ? 7'b0110011 : 7'b0111011};
          // addi to x0.
          3'd6: return {imm, rs1, 3'b000, 5'd0, 7'b0010011};
          default: return {imm, rs1, 3'b000, rd, 7'b1100111};
        endcase
      end
    endcase
  endfunction

  // one four-phase transfer with a random hold of the request.
  task automatic issue(input logic [31:0] word);
    int hold;
    hold = rand_bits(3);
    inst     <= word;
    inst_req <= 1'b1;
    @(posedge clk);
    while (!inst_ack) @(posedge clk);
    repeat (hold) @(posedge clk);
    inst_req <= 1'b0;
    @(posedge clk);
    while (inst_ack) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    seed = 32'h694ccbd0;
    reset    <= 1'b1;
    inst_req <= 1'b0;
    inst     <= '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // lui then addi into every register.
    for (int r = 1; r < 32; r++) begin
      issue({20'(rand_bits(20)), 5'(r), 7'b0110111});
      issue({12'(rand_bits(12)), 5'(r), 3'b000, 5'(r), 7'b0010011});
    end
    for (int t = 1; t <= 5; t++) begin
      for (int n = 0; n < 200; n++) issue(make_inst(t));
      $display("test %0d %s finished: %0d checks passed, %0d errors so far",
               t, test_names[t], passes, errors);
    end
    $display("total: %0d checks passed, %0d errors", passes, errors);
    if (errors == 0 && passes > 0) $display("Simulation completed successfully");
    else $display("Simulation failed");
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* vlog.f */
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_issue_ctrl.sv
src/rv_exec_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds with verilator, runs, and passes only if the pass message shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_top -o sim &&
  ./obj_dir/sim | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null &&
  echo "run passed" || { echo "run failed"; exit 1; }
